//--- include/tau_defines.svh
// Build-wide size macros for the collect path, included by the package and by sized modules
`ifndef TAU_DEFINES_SVH
`define TAU_DEFINES_SVH

// ==============================
// Descriptor geometry
// ==============================

// Vector dimensions per descriptor
`define TAU_VDIM 2

// Width of one coordinate
`define TAU_WORK_BW 16

// ==============================
// Slot array and linear words
// ==============================

// Slot count, may vary per build
`define TAU_N_ICFG 4

// Slot index, wide enough to hold the count itself
`define TAU_ICFG_BW ($clog2(`TAU_N_ICFG + 1))

// Linear address width, may vary per build
`define TAU_LBW 12

// Upper address bits selecting a memory bank
`define TAU_BANK_BW 2

// Remaining bits address a word inside the bank
`define TAU_OFS_BW (`TAU_LBW - `TAU_BANK_BW)

`endif

//--- logic/tau_pkg.sv
// Shared types of the collect path; modules refer to them by scoped name
`default_nettype none

`include "tau_defines.svh"

package tau_pkg;

	// ==============================
	// Descriptor types
	// ==============================

	// One coordinate per dimension, dimension 0 in the low bits
	typedef logic [`TAU_VDIM-1:0][`TAU_WORK_BW-1:0] coord_vec_t;

	// Slot number, also used for the exclusive end of a window
	typedef logic [`TAU_ICFG_BW-1:0] slot_idx_t;

	// ==============================
	// Linear word
	// ==============================

	// Bank select in the upper bits, offset below
	typedef struct packed {
		logic [`TAU_BANK_BW-1:0] bank;
		logic [`TAU_OFS_BW-1:0]  offset;
	} bank_ofs_t;

	// Same word seen flat by the collector, split by the drain
	typedef union packed {
		logic [`TAU_LBW-1:0] flat;
		bank_ofs_t           split;
	} linear_word_u;

	// Whole collected set, slot 0 in the low bits
	typedef linear_word_u [`TAU_N_ICFG-1:0] slot_array_t;

endpackage

`default_nettype wire

//--- logic/range_if.sv
// Range descriptor bus with ready/acknowledge, from the intake register to the collector
`timescale 1ns/100ps
`default_nettype none

interface range_if;

	// Handshake pair
	logic rdy;
	logic ack;

	// Descriptor coordinates
	tau_pkg::coord_vec_t bofs;
	tau_pkg::coord_vec_t abeg;
	tau_pkg::coord_vec_t aend;

	// Slot window, first slot and exclusive end
	tau_pkg::slot_idx_t beg;
	tau_pkg::slot_idx_t fin;

	// Sender side, holds data stable while rdy waits for ack
	modport src (
		output rdy, bofs, abeg, aend, beg, fin,
		input  ack
	);

	// Receiver side
	modport dst (
		input  rdy, bofs, abeg, aend, beg, fin,
		output ack
	);

endinterface

`default_nettype wire

//--- logic/linears_if.sv
// Collected slot set bus with ready/acknowledge, from the collector to the drain
`timescale 1ns/100ps
`default_nettype none

interface linears_if;

	// Handshake pair
	logic rdy;
	logic ack;

	// Descriptor of the range that produced the set
	tau_pkg::coord_vec_t bofs;
	tau_pkg::coord_vec_t abeg;
	tau_pkg::coord_vec_t aend;

	// Filled window, slots outside it carry stale words
	tau_pkg::slot_idx_t beg;
	tau_pkg::slot_idx_t fin;

	// All slot words
	tau_pkg::slot_array_t slots;

	// Collector side
	modport src (
		output rdy, bofs, abeg, aend, beg, fin, slots,
		input  ack
	);

	// Drain side
	modport dst (
		input  rdy, bofs, abeg, aend, beg, fin, slots,
		output ack
	);

endinterface

`default_nettype wire

//--- logic/range_intake.sv
// Input side of the collect path; one-entry forward register from the range ports onto range_if
`timescale 1ns/100ps
`default_nettype none

module range_intake (
	input  wire logic                i_clk,
	input  wire logic                i_rst,
	// External range port
	input  wire logic                i_range_rdy,
	output logic                     o_range_ack,
	input  wire tau_pkg::coord_vec_t i_bofs,
	input  wire tau_pkg::coord_vec_t i_abeg,
	input  wire tau_pkg::coord_vec_t i_aend,
	input  wire tau_pkg::slot_idx_t  i_beg,
	input  wire tau_pkg::slot_idx_t  i_end,
	// Toward the collector
	range_if.src                     o_range_bus
);

	// ==============================
	// Entry state
	// ==============================

	logic                full_r;
	logic                in_xfer;
	logic                out_xfer;
	tau_pkg::coord_vec_t bofs_r;
	tau_pkg::coord_vec_t abeg_r;
	tau_pkg::coord_vec_t aend_r;
	tau_pkg::slot_idx_t  beg_r;
	tau_pkg::slot_idx_t  end_r;

	// Accept only into an empty entry, so no same-cycle refill
	assign o_range_ack = !full_r;
	assign in_xfer     = i_range_rdy && !full_r;
	assign out_xfer    = full_r && o_range_bus.ack;

	// Entry drives the bus directly
	assign o_range_bus.rdy  = full_r;
	assign o_range_bus.bofs = bofs_r;
	assign o_range_bus.abeg = abeg_r;
	assign o_range_bus.aend = aend_r;
	assign o_range_bus.beg  = beg_r;
	assign o_range_bus.fin  = end_r;

	// ==============================
	// Sequential
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			full_r <= 1'b0;
			bofs_r <= '0;
			abeg_r <= '0;
			aend_r <= '0;
			beg_r  <= '0;
			end_r  <= '0;
		end else if (in_xfer) begin
			full_r <= 1'b1;
			bofs_r <= i_bofs;
			abeg_r <= i_abeg;
			aend_r <= i_aend;
			beg_r  <= i_beg;
			end_r  <= i_end;
		end else if (out_xfer) begin
			// Fields stay put, only the flag drops
			full_r <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/linear_collector.sv
// Collect stage; takes one range, fills its slot window from the linear stream, then offers the set
`timescale 1ns/100ps
`default_nettype none

`include "tau_defines.svh"

module linear_collector (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	// Range from the intake
	range_if.dst                       i_range_bus,
	// Linear address stream
	input  wire logic                  i_linear_rdy,
	output logic                       o_linear_ack,
	input  wire tau_pkg::linear_word_u i_linear,
	// Finished set toward the drain
	linears_if.src                     o_linears_bus
);

	// ==============================
	// State
	// ==============================

	// Collecting a window
	logic                 busy_r;
	// Set complete, waiting for the drain
	logic                 done_r;
	// Descriptor of the range in hand
	tau_pkg::coord_vec_t  bofs_r;
	tau_pkg::coord_vec_t  abeg_r;
	tau_pkg::coord_vec_t  aend_r;
	tau_pkg::slot_idx_t   beg_r;
	tau_pkg::slot_idx_t   end_r;
	// Next slot to write
	tau_pkg::slot_idx_t   cur_r;
	tau_pkg::slot_array_t slots_r;

	logic                 idle;
	logic                 range_xfer;
	logic                 set_xfer;
	logic                 last_slot;
	tau_pkg::slot_idx_t   cur_nxt;

	// ==============================
	// Combinational
	// ==============================

	// Neither collecting nor holding a finished set
	assign idle = !busy_r && !done_r;

	// Range taken in the same cycle it shows up
	assign i_range_bus.ack = idle;
	assign range_xfer      = i_range_bus.rdy && idle;

	// One address per cycle while the window is open
	assign o_linear_ack = busy_r && i_linear_rdy;

	assign cur_nxt   = tau_pkg::slot_idx_t'(cur_r + 1'b1);
	// Completion decided here, on the write into slot end-1
	assign last_slot = cur_nxt == end_r;

	assign set_xfer = done_r && o_linears_bus.ack;

	assign o_linears_bus.rdy   = done_r;
	assign o_linears_bus.bofs  = bofs_r;
	assign o_linears_bus.abeg  = abeg_r;
	assign o_linears_bus.aend  = aend_r;
	assign o_linears_bus.beg   = beg_r;
	assign o_linears_bus.fin   = end_r;
	assign o_linears_bus.slots = slots_r;

	// ==============================
	// Control and descriptor
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy_r <= 1'b0;
			done_r <= 1'b0;
			bofs_r <= '0;
			abeg_r <= '0;
			aend_r <= '0;
			beg_r  <= '0;
			end_r  <= '0;
			cur_r  <= '0;
		end else begin
			if (range_xfer) begin
				busy_r <= 1'b1;
				bofs_r <= i_range_bus.bofs;
				abeg_r <= i_range_bus.abeg;
				aend_r <= i_range_bus.aend;
				beg_r  <= i_range_bus.beg;
				end_r  <= i_range_bus.fin;
				// Start at the first slot of the window
				cur_r  <= i_range_bus.beg;
			end else if (o_linear_ack) begin
				cur_r <= cur_nxt;
				if (last_slot) begin
					busy_r <= 1'b0;
					done_r <= 1'b1;
				end
			end
			// Drain copied the set
			if (set_xfer) begin
				done_r <= 1'b0;
			end
		end
	end

	// ==============================
	// Slot array
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			slots_r <= '0;
		end else if (o_linear_ack) begin
			for (int i = 0; i < `TAU_N_ICFG; i++) begin
				if (cur_r == tau_pkg::slot_idx_t'(i)) begin
					slots_r[i].flat <= i_linear.flat;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/linears_drain.sv
// Output side; holds one collected set and sends its window as bank/offset words, one per cycle
`timescale 1ns/100ps
`default_nettype none

`include "tau_defines.svh"

module linears_drain (
	input  wire logic                   i_clk,
	input  wire logic                   i_rst,
	// Collected set from the collector
	linears_if.dst                      i_linears_bus,
	// Word output port
	output logic                        o_word_rdy,
	input  wire logic                   i_word_ack,
	output logic [`TAU_BANK_BW-1:0]     o_word_bank,
	output logic [`TAU_OFS_BW-1:0]      o_word_offset,
	output tau_pkg::slot_idx_t          o_word_slot,
	output logic                        o_word_last,
	output tau_pkg::coord_vec_t         o_bofs,
	output tau_pkg::coord_vec_t         o_abeg,
	output tau_pkg::coord_vec_t         o_aend
);

	// ==============================
	// Held set
	// ==============================

	logic                  full_r;
	tau_pkg::slot_idx_t    cur_r;
	tau_pkg::slot_idx_t    end_r;
	tau_pkg::slot_array_t  slots_r;
	tau_pkg::linear_word_u word;
	logic                  set_xfer;
	logic                  word_xfer;

	// Empty drain takes the set in the cycle it is offered
	assign i_linears_bus.ack = !full_r;
	assign set_xfer          = i_linears_bus.rdy && !full_r;

	assign o_word_rdy  = full_r;
	assign word_xfer   = full_r && i_word_ack;
	assign o_word_slot = cur_r;
	// Slot end-1 closes the set
	assign o_word_last = tau_pkg::slot_idx_t'(cur_r + 1'b1) == end_r;

	// Pick the current slot
	always_comb begin
		word = '0;
		for (int i = 0; i < `TAU_N_ICFG; i++) begin
			if (cur_r == tau_pkg::slot_idx_t'(i)) begin
				word = slots_r[i];
			end
		end
	end

	// Bank/offset view of the stored address
	assign o_word_bank   = word.split.bank;
	assign o_word_offset = word.split.offset;

	// ==============================
	// Sequential
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			full_r  <= 1'b0;
			cur_r   <= '0;
			end_r   <= '0;
			slots_r <= '0;
			o_bofs  <= '0;
			o_abeg  <= '0;
			o_aend  <= '0;
		end else if (set_xfer) begin
			full_r  <= 1'b1;
			cur_r   <= i_linears_bus.beg;
			end_r   <= i_linears_bus.fin;
			slots_r <= i_linears_bus.slots;
			o_bofs  <= i_linears_bus.bofs;
			o_abeg  <= i_linears_bus.abeg;
			o_aend  <= i_linears_bus.aend;
		end else if (word_xfer) begin
			// Free after the last word, else step to the next slot
			if (o_word_last) begin
				full_r <= 1'b0;
			end else begin
				cur_r <= tau_pkg::slot_idx_t'(cur_r + 1'b1);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/tau_collect_top.sv
// Top level of the linear collect path; plain range, linear and word ports around three stages
`timescale 1ns/100ps
`default_nettype none

`include "tau_defines.svh"

module tau_collect_top (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	// Range input
	input  wire logic                  i_range_rdy,
	output logic                       o_range_ack,
	input  wire tau_pkg::coord_vec_t   i_bofs,
	input  wire tau_pkg::coord_vec_t   i_abeg,
	input  wire tau_pkg::coord_vec_t   i_aend,
	input  wire tau_pkg::slot_idx_t    i_beg,
	input  wire tau_pkg::slot_idx_t    i_end,
	// Linear address input
	input  wire logic                  i_linear_rdy,
	output logic                       o_linear_ack,
	input  wire tau_pkg::linear_word_u i_linear,
	// Word output
	output logic                       o_word_rdy,
	input  wire logic                  i_word_ack,
	output logic [`TAU_BANK_BW-1:0]    o_word_bank,
	output logic [`TAU_OFS_BW-1:0]     o_word_offset,
	output tau_pkg::slot_idx_t         o_word_slot,
	output logic                       o_word_last,
	output tau_pkg::coord_vec_t        o_bofs,
	output tau_pkg::coord_vec_t        o_abeg,
	output tau_pkg::coord_vec_t        o_aend
);

	// ==============================
	// Internal buses
	// ==============================

	range_if   range_bus ();
	linears_if linears_bus ();

	// ==============================
	// Stages
	// ==============================

	// Registers one descriptor
	range_intake u_intake (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_range_rdy (i_range_rdy),
		.o_range_ack (o_range_ack),
		.i_bofs      (i_bofs),
		.i_abeg      (i_abeg),
		.i_aend      (i_aend),
		.i_beg       (i_beg),
		.i_end       (i_end),
		.o_range_bus (range_bus.src)
	);

	// Fills the slot window
	linear_collector u_collector (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_range_bus   (range_bus.dst),
		.i_linear_rdy  (i_linear_rdy),
		.o_linear_ack  (o_linear_ack),
		.i_linear      (i_linear),
		.o_linears_bus (linears_bus.src)
	);

	// Sends the window as words
	linears_drain u_drain (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_linears_bus (linears_bus.dst),
		.o_word_rdy    (o_word_rdy),
		.i_word_ack    (i_word_ack),
		.o_word_bank   (o_word_bank),
		.o_word_offset (o_word_offset),
		.o_word_slot   (o_word_slot),
		.o_word_last   (o_word_last),
		.o_bofs        (o_bofs),
		.o_abeg        (o_abeg),
		.o_aend        (o_aend)
	);

endmodule

`default_nettype wire

//--- dv/tau_collect_assert.sv
// Handshake and window assertions for the collect path top level, attached to it with bind
`timescale 1ns/100ps
`default_nettype none

`include "tau_defines.svh"

module tau_collect_assert (
	input wire logic                    i_clk,
	input wire logic                    i_rst,
	input wire logic                    i_range_rdy,
	input wire logic                    o_range_ack,
	input wire tau_pkg::coord_vec_t     i_bofs,
	input wire tau_pkg::coord_vec_t     i_abeg,
	input wire tau_pkg::coord_vec_t     i_aend,
	input wire tau_pkg::slot_idx_t      i_beg,
	input wire tau_pkg::slot_idx_t      i_end,
	input wire logic                    i_linear_rdy,
	input wire logic                    o_linear_ack,
	input wire logic [`TAU_LBW-1:0]     i_linear,
	input wire logic                    o_word_rdy,
	input wire logic                    i_word_ack,
	input wire logic [`TAU_BANK_BW-1:0] o_word_bank,
	input wire logic [`TAU_OFS_BW-1:0]  o_word_offset,
	input wire tau_pkg::slot_idx_t      o_word_slot,
	input wire logic                    o_word_last,
	input wire tau_pkg::coord_vec_t     o_bofs,
	input wire tau_pkg::coord_vec_t     o_abeg,
	input wire tau_pkg::coord_vec_t     o_aend
);

	// First range taken since reset
	logic seen_range_r;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			seen_range_r <= 1'b0;
		end else if (i_range_rdy && o_range_ack) begin
			seen_range_r <= 1'b1;
		end
	end

	// ==============================
	// Stable until ack
	// ==============================

	range_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_range_rdy && !o_range_ack |=>
		i_range_rdy && $stable({i_bofs, i_abeg, i_aend, i_beg, i_end}))
		else $error("range input dropped or changed before its ack");

	linear_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_linear_rdy && !o_linear_ack |=> i_linear_rdy && $stable(i_linear))
		else $error("linear input dropped or changed before its ack");

	word_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_word_rdy && !i_word_ack |=>
		o_word_rdy && $stable({o_word_bank, o_word_offset, o_word_slot, o_word_last,
			o_bofs, o_abeg, o_aend}))
		else $error("output word dropped or changed before its ack");

	// ==============================
	// Window and start-up
	// ==============================

	// Non-empty window inside the slot array
	window_rule: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_range_rdy && o_range_ack |->
		i_beg < i_end && i_end <= tau_pkg::slot_idx_t'(`TAU_N_ICFG))
		else $error("accepted range breaks the window rule");

	no_early_word: assert property (@(posedge i_clk) disable iff (!i_rst)
		!seen_range_r |-> !o_word_rdy)
		else $error("output word offered before any range");

endmodule

bind tau_collect_top tau_collect_assert u_assert (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_range_rdy   (i_range_rdy),
	.o_range_ack   (o_range_ack),
	.i_bofs        (i_bofs),
	.i_abeg        (i_abeg),
	.i_aend        (i_aend),
	.i_beg         (i_beg),
	.i_end         (i_end),
	.i_linear_rdy  (i_linear_rdy),
	.o_linear_ack  (o_linear_ack),
	.i_linear      (i_linear),
	.o_word_rdy    (o_word_rdy),
	.i_word_ack    (i_word_ack),
	.o_word_bank   (o_word_bank),
	.o_word_offset (o_word_offset),
	.o_word_slot   (o_word_slot),
	.o_word_last   (o_word_last),
	.o_bofs        (o_bofs),
	.o_abeg        (o_abeg),
	.o_aend        (o_aend)
);

`default_nettype wire

//--- dv/tb_tau_collect.sv
// Testbench for the collect path top level; directed and random ranges checked against a reference
`timescale 1ns/100ps
`default_nettype none

`include "tau_defines.svh"

module tb_tau_collect;

	// ==============================
	// Types and limits
	// ==============================

	typedef logic [`TAU_LBW-1:0] lin_t;
	// Linears of one range in slot order from beg
	typedef lin_t [`TAU_N_ICFG-1:0] lin_set_t;

	typedef struct packed {
		tau_pkg::coord_vec_t bofs;
		tau_pkg::coord_vec_t abeg;
		tau_pkg::coord_vec_t aend;
		tau_pkg::slot_idx_t  beg;
		tau_pkg::slot_idx_t  fin;
	} range_t;

	// One expected output word
	typedef struct packed {
		tau_pkg::slot_idx_t      slot;
		logic [`TAU_BANK_BW-1:0] bank;
		logic [`TAU_OFS_BW-1:0]  offset;
		logic                    last;
		tau_pkg::coord_vec_t     bofs;
		tau_pkg::coord_vec_t     abeg;
		tau_pkg::coord_vec_t     aend;
	} word_t;

	// Idle cycles any single wait may take
	localparam int WAIT_LIMIT = 200;

	// ==============================
	// DUT signals
	// ==============================

	logic                    clk;
	logic                    rst;
	logic                    range_rdy;
	logic                    range_ack;
	tau_pkg::coord_vec_t     bofs_in;
	tau_pkg::coord_vec_t     abeg_in;
	tau_pkg::coord_vec_t     aend_in;
	tau_pkg::slot_idx_t      beg_in;
	tau_pkg::slot_idx_t      end_in;
	logic                    lin_rdy;
	logic                    lin_ack;
	lin_t                    lin_in;
	logic                    word_rdy;
	logic                    word_ack;
	logic [`TAU_BANK_BW-1:0] word_bank;
	logic [`TAU_OFS_BW-1:0]  word_offset;
	tau_pkg::slot_idx_t      word_slot;
	logic                    word_last;
	tau_pkg::coord_vec_t     bofs_out;
	tau_pkg::coord_vec_t     abeg_out;
	tau_pkg::coord_vec_t     aend_out;

	// Stimulus and expected words in arrival order
	range_t      range_q[$];
	lin_t        lin_q[$];
	word_t       exp_q[$];
	logic [31:0] lfsr_state;
	int          err_cnt;
	int          n_pass;
	int          n_fail;
	logic        timeout_hit;

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	tau_collect_top UUT (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_range_rdy   (range_rdy),
		.o_range_ack   (range_ack),
		.i_bofs        (bofs_in),
		.i_abeg        (abeg_in),
		.i_aend        (aend_in),
		.i_beg         (beg_in),
		.i_end         (end_in),
		.i_linear_rdy  (lin_rdy),
		.o_linear_ack  (lin_ack),
		.i_linear      (lin_in),
		.o_word_rdy    (word_rdy),
		.i_word_ack    (word_ack),
		.o_word_bank   (word_bank),
		.o_word_offset (word_offset),
		.o_word_slot   (word_slot),
		.o_word_last   (word_last),
		.o_bofs        (bofs_out),
		.o_abeg        (abeg_out),
		.o_aend        (aend_out)
	);

	// ==============================
	// Random source and reference
	// ==============================

	// Right-shifting Galois step
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One LFSR step per returned bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Expected words of one range for slots beg through end-1
	function automatic void build_expect(input range_t r, input lin_set_t lins);
		word_t w;
		int    k;
		k = 0;
		for (int s = int'(r.beg); s < int'(r.fin); s++) begin
			w.slot   = tau_pkg::slot_idx_t'(s);
			// Upper bits pick the bank and the rest is the offset
			w.bank   = lins[k][`TAU_LBW-1 -: `TAU_BANK_BW];
			w.offset = lins[k][`TAU_OFS_BW-1:0];
			w.last   = (s == int'(r.fin) - 1);
			w.bofs   = r.bofs;
			w.abeg   = r.abeg;
			w.aend   = r.aend;
			exp_q.push_back(w);
			k++;
		end
	endfunction

	// ==============================
	// Checks and reporting
	// ==============================

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT at %0t: %s", $time, what);
		timeout_hit = 1'b1;
		err_cnt++;
	endtask

	task automatic compare_word(input word_t e);
		check_val("o_word_slot", 64'(word_slot), 64'(e.slot));
		check_val("o_word_bank", 64'(word_bank), 64'(e.bank));
		check_val("o_word_offset", 64'(word_offset), 64'(e.offset));
		check_val("o_word_last", 64'(word_last), 64'(e.last));
		check_val("o_bofs", 64'(bofs_out), 64'(e.bofs));
		check_val("o_abeg", 64'(abeg_out), 64'(e.abeg));
		check_val("o_aend", 64'(aend_out), 64'(e.aend));
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			n_pass++;
			$display("test %s: pass", name);
		end else begin
			n_fail++;
			$display("test %s: fail, %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ==============================
	// Stimulus queues
	// ==============================

	// Random descriptor and linears for a given window
	task automatic add_window(input int b, input int f);
		range_t   r;
		lin_set_t lins;
		r.bofs = tau_pkg::coord_vec_t'(rand_bits(32));
		r.abeg = tau_pkg::coord_vec_t'(rand_bits(32));
		r.aend = tau_pkg::coord_vec_t'(rand_bits(32));
		r.beg  = tau_pkg::slot_idx_t'(b);
		r.fin  = tau_pkg::slot_idx_t'(f);
		for (int k = 0; k < `TAU_N_ICFG; k++) begin
			lins[k] = lin_t'(rand_bits(`TAU_LBW));
		end
		range_q.push_back(r);
		for (int k = 0; k < f - b; k++) begin
			lin_q.push_back(lins[k]);
		end
		build_expect(r, lins);
	endtask

	// Non-empty window anywhere inside the slot array
	task automatic add_random_range();
		int b;
		int f;
		b = int'(rand_bits(8)) % `TAU_N_ICFG;
		f = b + 1 + int'(rand_bits(8)) % (`TAU_N_ICFG - b);
		add_window(b, f);
	endtask

	// ==============================
	// Drivers and word sink
	// ==============================

	task automatic drive_range(input range_t r);
		int   waited;
		logic got;
		waited    = 0;
		got       = 1'b0;
		range_rdy = 1'b1;
		bofs_in   = r.bofs;
		abeg_in   = r.abeg;
		aend_in   = r.aend;
		beg_in    = r.beg;
		end_in    = r.fin;
		// Ack seen mid-cycle means a transfer at the next edge
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge clk);
			got = range_ack;
			@(posedge clk);
			#0.5;
			waited++;
		end
		range_rdy = 1'b0;
		if (!got) begin
			report_timeout("range input was never acknowledged");
		end
	endtask

	task automatic drive_linear(input lin_t v, input logic gaps);
		int   gap;
		int   waited;
		logic got;
		gap     = gaps ? int'(rand_bits(2)) : 0;
		waited  = 0;
		got     = 1'b0;
		lin_rdy = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#0.5;
		end
		lin_in  = v;
		lin_rdy = 1'b1;
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge clk);
			got = lin_ack;
			@(posedge clk);
			#0.5;
			waited++;
		end
		lin_rdy = 1'b0;
		if (!got) begin
			report_timeout("linear address was never acknowledged");
		end
	endtask

	// Takes and compares words; a larger ack_hold withholds the ack more often
	task automatic sink_words(input int n_words, input int ack_hold);
		int got_n;
		int waited;
		got_n  = 0;
		waited = 0;
		while (got_n < n_words && waited < WAIT_LIMIT && !timeout_hit) begin
			word_ack = (ack_hold == 0) || (int'(rand_bits(2)) >= ack_hold);
			@(negedge clk);
			if (word_rdy && word_ack) begin
				compare_word(exp_q.pop_front());
				got_n++;
				waited = 0;
			end else begin
				waited++;
			end
			@(posedge clk);
			#0.5;
		end
		word_ack = 1'b0;
		if (got_n < n_words && !timeout_hit) begin
			report_timeout("output words stopped before the expected count");
		end
	endtask

	task automatic run_batch(input string name, input logic gaps, input int ack_hold);
		int errs_before;
		int n_words;
		errs_before = err_cnt;
		n_words     = exp_q.size();
		fork
			begin
				while (range_q.size() > 0 && !timeout_hit) begin
					drive_range(range_q.pop_front());
				end
			end
			begin
				while (lin_q.size() > 0 && !timeout_hit) begin
					drive_linear(lin_q.pop_front(), gaps);
				end
			end
			sink_words(n_words, ack_hold);
		join
		// No extra word once the last one is out
		@(negedge clk);
		check_val("o_word_rdy", 64'(word_rdy), 64'd0);
		@(posedge clk);
		#0.5;
		finish_test(name, errs_before);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int errs_before;
		range_rdy   = 1'b0;
		bofs_in     = '0;
		abeg_in     = '0;
		aend_in     = '0;
		beg_in      = '0;
		end_in      = '0;
		lin_rdy     = 1'b0;
		lin_in      = '0;
		word_ack    = 1'b0;
		rst         = 1'b0;
		lfsr_state  = 32'h5dc6_106d;
		err_cnt     = 0;
		n_pass      = 0;
		n_fail      = 0;
		timeout_hit = 1'b0;
		errs_before = err_cnt;

		// Linear offered during reset finds the collector idle
		@(posedge clk);
		#0.5;
		lin_rdy = 1'b1;
		@(negedge clk);
		check_val("o_linear_ack", 64'(lin_ack), 64'd0);
		@(posedge clk);
		#0.5;
		lin_rdy = 1'b0;
		@(posedge clk);
		#0.5;
		rst = 1'b1;

		// Idle handshake levels
		@(negedge clk);
		check_val("o_range_ack", 64'(range_ack), 64'd1);
		check_val("o_linear_ack", 64'(lin_ack), 64'd0);
		check_val("o_word_rdy", 64'(word_rdy), 64'd0);
		@(posedge clk);
		#0.5;
		finish_test("1 reset state", errs_before);

		// Whole array with addresses spread over all banks
		begin
			range_t   r;
			lin_set_t lins;
			r.bofs = {16'h0002, 16'h0001};
			r.abeg = {16'h0010, 16'h0000};
			r.aend = {16'h0020, 16'h0040};
			r.beg  = '0;
			r.fin  = tau_pkg::slot_idx_t'(`TAU_N_ICFG);
			for (int k = 0; k < `TAU_N_ICFG; k++) begin
				lins[k] = lin_t'(32'h0A5C + k * 32'h0397);
				lin_q.push_back(lins[k]);
			end
			range_q.push_back(r);
			build_expect(r, lins);
			run_batch("2 full window", 1'b0, 0);
		end

		// Short windows at the start, middle and end
		if (!timeout_hit) begin
			add_window(`TAU_N_ICFG / 2, `TAU_N_ICFG / 2 + 1);
			add_window(1, `TAU_N_ICFG - 1);
			add_window(`TAU_N_ICFG - 1, `TAU_N_ICFG);
			add_window(0, 1);
			run_batch("3 single and mid windows", 1'b0, 0);
		end

		if (!timeout_hit) begin
			repeat (40) add_random_range();
			run_batch("4 random gaps and ack withholding", 1'b1, 1);
		end

		// Slow sink keeps all three stages full
		if (!timeout_hit) begin
			repeat (8) add_random_range();
			run_batch("5 back to back descriptors", 1'b0, 3);
		end

		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
		if (n_fail == 0 && err_cnt == 0 && !timeout_hit) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
logic/tau_pkg.sv
logic/range_if.sv
logic/linears_if.sv
logic/range_intake.sv
logic/linear_collector.sv
logic/linears_drain.sv
logic/tau_collect_top.sv
dv/tau_collect_assert.sv
dv/tb_tau_collect.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the collect path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f all.f --top-module tb_tau_collect -o sim_tau_collect

./obj_dir/sim_tau_collect | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
echo "simulation passed"
